// ==== rtl/commu_pkg.sv ====
// frame sender typedefs, register offsets, frame constants and sequencer states

package commu_pkg;

	// bus and datapath widths
	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [3:0]  frame_len_t;
	typedef logic [7:0]  seq_t;
	typedef logic [15:0] cnt_sent_t;

	// first byte of every head phase
	localparam byte_t FRAME_SYNC = 8'hA5;

	// largest payload, in bytes
	localparam int MAX_LEN = 8;

	// register map
	localparam apb_addr_t REG_CTRL   = 8'h00;
	localparam apb_addr_t REG_RETRY  = 8'h04;
	localparam apb_addr_t REG_LEN    = 8'h08;
	localparam apb_addr_t REG_PAY0   = 8'h10;
	localparam apb_addr_t REG_PAY1   = 8'h14;
	localparam apb_addr_t REG_STATUS = 8'h18;

	// sequencer states
	typedef enum logic [3:0] {
		IDLE   = 4'h0,
		FIRE_H = 4'h1,
		WAIT_H = 4'h2,
		FIRE_P = 4'h3,
		WAIT_P = 4'h4,
		FIRE_T = 4'h5,
		WAIT_T = 4'h6,
		BUF    = 4'hA,
		BUF2   = 4'hB,
		DONE   = 4'hF
	} main_state_t;

endpackage

// ==== rtl/commu_regs.sv ====
// APB register block with control, retry, length, payload and status registers
`timescale 1ns/100ps

module commu_regs (
	input  logic                                  clk_sys,
	input  logic                                  rst_n,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  commu_pkg::apb_addr_t                  paddr,
	input  commu_pkg::apb_data_t                  pwdata,
	output commu_pkg::apb_data_t                  prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	input  logic                                  busy,
	input  logic                                  frame_done,
	input  commu_pkg::seq_t                       seq,
	output logic                                  send_pend,
	output commu_pkg::byte_t                      retry_code,
	output commu_pkg::frame_len_t                 len,
	output logic [8*commu_pkg::MAX_LEN-1:0]       payload
);
	import commu_pkg::*;

	apb_data_t pay0;
	apb_data_t pay1;
	cnt_sent_t cnt_sent;
	seq_t      seq_q;
	logic      busy_q;
	logic      access;
	logic      addr_hit;
	logic      wr_en;
	logic      start;
	logic      took_send;
	logic      took_retry;

	// --------------------
	// APB decode
	// --------------------
	assign access = psel & penable;
	assign pready = 1'b1;

	always_comb begin
		case (paddr)
			REG_CTRL, REG_RETRY, REG_LEN, REG_PAY0, REG_PAY1, REG_STATUS: addr_hit = 1'b1;
			default: addr_hit = 1'b0;
		endcase
	end

	// status is read only
	assign pslverr = access & (~addr_hit | (pwrite & (paddr == REG_STATUS)));
	assign wr_en   = access & pwrite & ~pslverr;

	always_comb begin
		case (paddr)
			REG_CTRL:   prdata = apb_data_t'({busy, send_pend});
			REG_RETRY:  prdata = apb_data_t'(retry_code);
			REG_LEN:    prdata = apb_data_t'(len);
			REG_PAY0:   prdata = pay0;
			REG_PAY1:   prdata = pay1;
			REG_STATUS: prdata = apb_data_t'({seq, cnt_sent});
			default:    prdata = '0;
		endcase
	end

	// --------------------
	// request hand-off
	// --------------------
	// first busy cycle; a send path shows up as a fresh sequence number
	assign start      = busy & ~busy_q;
	assign took_send  = start & (seq != seq_q);
	assign took_retry = start & ~took_send & retry_code[0] & retry_code[1];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy_q     <= 1'b0;
			seq_q      <= '0;
			send_pend  <= 1'b0;
			retry_code <= '0;
			len        <= '0;
			cnt_sent   <= '0;
		end else begin
			busy_q <= busy;
			seq_q  <= seq;

			// a new write wins over the hand-off clear
			if (wr_en && (paddr == REG_CTRL) && pwdata[0])
				send_pend <= 1'b1;
			else if (took_send)
				send_pend <= 1'b0;

			if (wr_en && (paddr == REG_RETRY))
				retry_code <= pwdata[7:0];
			else if (took_retry)
				retry_code <= '0;

			// clamp to the largest payload
			if (wr_en && (paddr == REG_LEN)) begin
				if (pwdata > apb_data_t'(MAX_LEN))
					len <= frame_len_t'(MAX_LEN);
				else
					len <= pwdata[3:0];
			end

			if (frame_done)
				cnt_sent <= cnt_sent + 1'b1;
		end
	end

	// payload bytes
	always_ff @(posedge clk_sys) begin
		if (wr_en && (paddr == REG_PAY0))
			pay0 <= pwdata;
		if (wr_en && (paddr == REG_PAY1))
			pay1 <= pwdata;
	end

	// byte 0 is the low byte of pay0
	assign payload = {pay1, pay0};

endmodule

// ==== rtl/commu_main.sv ====
// frame sequencer FSM with receive holdoff and guard counter
`timescale 1ns/100ps

module commu_main #(
	parameter int unsigned GUARD_CYCLES = 100
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic             rx_active,
	input  logic             slot_rdy,
	input  commu_pkg::byte_t cmd_retry,
	input  logic             done_head,
	input  logic             done_push,
	input  logic             done_tail,
	output logic             fire_head,
	output logic             fire_push,
	output logic             fire_tail,
	output logic             seq_adv,
	output logic             frame_done,
	output logic             busy
);
	import commu_pkg::*;

	localparam int unsigned GUARD_W = $clog2(GUARD_CYCLES + 1);

	main_state_t        state;
	main_state_t        state_nxt;
	logic [GUARD_W-1:0] guard_cnt;
	logic               retry_ok;
	logic               guard_end;

	// retry needs both low code bits
	assign retry_ok  = cmd_retry[0] & cmd_retry[1];
	assign guard_end = (guard_cnt == GUARD_W'(GUARD_CYCLES - 1));

	// --------------------
	// state register
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				// line busy first, then send, then retry
				if (rx_active)
					state_nxt = BUF;
				else if (slot_rdy || retry_ok)
					state_nxt = FIRE_H;
			end
			FIRE_H: state_nxt = WAIT_H;
			WAIT_H: if (done_head) state_nxt = FIRE_P;
			FIRE_P: state_nxt = WAIT_P;
			WAIT_P: if (done_push) state_nxt = FIRE_T;
			FIRE_T: state_nxt = WAIT_T;
			WAIT_T: if (done_tail) state_nxt = DONE;
			BUF:    if (!rx_active) state_nxt = BUF2;
			BUF2:   if (guard_end) state_nxt = IDLE;
			DONE:   state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	// --------------------
	// quiet time after rx
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			guard_cnt <= '0;
		else if (state == BUF2)
			guard_cnt <= guard_cnt + 1'b1;
		else
			guard_cnt <= '0;
	end

	// phase strobes
	assign fire_head  = (state == FIRE_H);
	assign fire_push  = (state == FIRE_P);
	assign fire_tail  = (state == FIRE_T);
	assign frame_done = (state == DONE);
	assign busy       = (state != IDLE);

	// only a fresh send bumps the sequence number
	assign seq_adv = (state == IDLE) & ~rx_active & slot_rdy;

endmodule

// ==== rtl/commu_phase_tx.sv ====
// phase byte generator with sequence counter and running checksum
`timescale 1ns/100ps

module commu_phase_tx (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            fire_head,
	input  logic                            fire_push,
	input  logic                            fire_tail,
	input  commu_pkg::frame_len_t           len,
	input  logic [8*commu_pkg::MAX_LEN-1:0] payload,
	input  logic                            seq_adv,
	output logic                            done_head,
	output logic                            done_push,
	output logic                            done_tail,
	output commu_pkg::byte_t                tx_data,
	output logic                            tx_valid,
	input  logic                            tx_ready,
	output commu_pkg::seq_t                 seq
);
	import commu_pkg::*;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_HEAD,
		PH_PUSH,
		PH_TAIL
	} phase_t;

	phase_t     phase;
	frame_len_t idx;
	frame_len_t idx_nxt;
	frame_len_t len_q;
	byte_t      csum;
	logic       xfer;
	logic       last_byte;

	assign xfer    = tx_valid & tx_ready;
	assign idx_nxt = idx + 1'b1;

	always_comb begin
		case (phase)
			PH_HEAD: last_byte = (idx == 4'd2);
			PH_PUSH: last_byte = (idx == len_q - 1'b1);
			PH_TAIL: last_byte = 1'b1;
			default: last_byte = 1'b0;
		endcase
	end

	// --------------------
	// phase control
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			phase     <= PH_IDLE;
			tx_valid  <= 1'b0;
			done_head <= 1'b0;
			done_push <= 1'b0;
			done_tail <= 1'b0;
			seq       <= '0;
		end else begin
			done_head <= 1'b0;
			done_push <= 1'b0;
			done_tail <= 1'b0;

			if (seq_adv)
				seq <= seq + 1'b1;

			if (fire_head) begin
				phase    <= PH_HEAD;
				tx_valid <= 1'b1;
			end else if (fire_push) begin
				// empty payload answers straight away
				if (len_q == '0) begin
					done_push <= 1'b1;
				end else begin
					phase    <= PH_PUSH;
					tx_valid <= 1'b1;
				end
			end else if (fire_tail) begin
				phase    <= PH_TAIL;
				tx_valid <= 1'b1;
			end else if (xfer && last_byte) begin
				phase    <= PH_IDLE;
				tx_valid <= 1'b0;
				done_head <= (phase == PH_HEAD);
				done_push <= (phase == PH_PUSH);
				done_tail <= (phase == PH_TAIL);
			end
		end
	end

	// --------------------
	// byte datapath
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (fire_head) begin
			idx     <= '0;
			len_q   <= len;
			tx_data <= FRAME_SYNC;
			// seq already stepped by now
			csum    <= seq ^ len;
		end else if (fire_push) begin
			idx     <= '0;
			tx_data <= payload[7:0];
		end else if (fire_tail) begin
			tx_data <= csum;
		end else if (xfer && !last_byte) begin
			idx <= idx_nxt;
			if (phase == PH_HEAD)
				tx_data <= (idx == '0) ? seq : len_q;
			else
				tx_data <= payload[8*idx_nxt +: 8];
		end

		// fold in each payload byte as it leaves
		if (xfer && (phase == PH_PUSH))
			csum <= csum ^ tx_data;
	end

endmodule

// ==== rtl/commu_top.sv ====
// frame sender top level with register block, sequencer and phase transmitter
`timescale 1ns/100ps

module commu_top #(
	parameter int unsigned GUARD_CYCLES = 100
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  commu_pkg::apb_addr_t paddr,
	input  commu_pkg::apb_data_t pwdata,
	output commu_pkg::apb_data_t prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  logic                 rx_active,
	output commu_pkg::byte_t     tx_data,
	output logic                 tx_valid,
	input  logic                 tx_ready
);
	import commu_pkg::*;

	// requests and status
	logic                   send_pend;
	byte_t                  retry_code;
	frame_len_t             len;
	logic [8*MAX_LEN-1:0]   payload;
	seq_t                   seq;
	logic                   busy;
	logic                   frame_done;
	logic                   seq_adv;

	// phase handshake
	logic fire_head;
	logic fire_push;
	logic fire_tail;
	logic done_head;
	logic done_push;
	logic done_tail;

	commu_regs u_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.busy       (busy),
		.frame_done (frame_done),
		.seq        (seq),
		.send_pend  (send_pend),
		.retry_code (retry_code),
		.len        (len),
		.payload    (payload)
	);

	commu_main #(
		.GUARD_CYCLES (GUARD_CYCLES)
	) u_main (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rx_active  (rx_active),
		.slot_rdy   (send_pend),
		.cmd_retry  (retry_code),
		.done_head  (done_head),
		.done_push  (done_push),
		.done_tail  (done_tail),
		.fire_head  (fire_head),
		.fire_push  (fire_push),
		.fire_tail  (fire_tail),
		.seq_adv    (seq_adv),
		.frame_done (frame_done),
		.busy       (busy)
	);

	commu_phase_tx u_phase_tx (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.fire_head (fire_head),
		.fire_push (fire_push),
		.fire_tail (fire_tail),
		.len       (len),
		.payload   (payload),
		.seq_adv   (seq_adv),
		.done_head (done_head),
		.done_push (done_push),
		.done_tail (done_tail),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.seq       (seq)
	);

endmodule

// ==== verification/commu_main_checker.sv ====
// concurrent checks on the sequencer pulses, phase order and byte stream stalls
`timescale 1ns/100ps

module commu_main_checker (
	input logic             clk_sys,
	input logic             rst_n,
	input logic             rx_active,
	input logic             fire_head,
	input logic             fire_push,
	input logic             fire_tail,
	input logic             done_head,
	input logic             done_push,
	input logic             done_tail,
	input commu_pkg::byte_t tx_data,
	input logic             tx_valid,
	input logic             tx_ready
);

	// next fire expected in the frame as 0 head, 1 push or 2 tail
	logic [1:0] phase_exp;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			phase_exp <= 2'd0;
		else if (fire_head)
			phase_exp <= 2'd1;
		else if (fire_push)
			phase_exp <= 2'd2;
		else if (fire_tail)
			phase_exp <= 2'd0;
	end

	// --------------------
	// single cycle strobes
	// --------------------
	a_fire_head_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_head |=> !fire_head) else $error("fire_head longer than one cycle");
	a_fire_push_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_push |=> !fire_push) else $error("fire_push longer than one cycle");
	a_fire_tail_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_tail |=> !fire_tail) else $error("fire_tail longer than one cycle");
	a_done_head_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		done_head |=> !done_head) else $error("done_head longer than one cycle");
	a_done_push_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		done_push |=> !done_push) else $error("done_push longer than one cycle");
	a_done_tail_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		done_tail |=> !done_tail) else $error("done_tail longer than one cycle");

	// --------------------
	// phase order
	// --------------------
	a_head_order: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_head |-> (phase_exp == 2'd0)) else $error("fire_head out of order");
	a_push_order: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_push |-> (phase_exp == 2'd1)) else $error("fire_push out of order");
	a_tail_order: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_tail |-> (phase_exp == 2'd2)) else $error("fire_tail out of order");

	// line is owned by the receiver
	a_rx_quiet: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(fire_head || fire_push || fire_tail) |-> !rx_active)
		else $error("phase fired during a received frame");

	// byte held under back-pressure
	a_stall_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)))
		else $error("stream byte changed while stalled");

endmodule

// ==== verification/commu_tb.sv ====
// testbench for the frame sender: clock, reset, APB tasks, stream sink, model and tests
`timescale 1ns/100ps

module commu_tb;
	import commu_pkg::*;

	localparam int unsigned GUARD      = 20;
	localparam int          WAIT_LIMIT = 2000;
	localparam logic [31:0] SEED       = 32'hd092_ebaa;

	logic      clk_sys;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      rx_active;
	byte_t     tx_data;
	logic      tx_valid;
	logic      tx_ready;

	logic [31:0] lfsr_state;
	int          n_tests;
	int          n_failed;
	int          n_checks;
	int          n_errors;
	int          err_base;
	string       cur_test;
	byte_t       rx_q[$];
	byte_t       exp_q[$];
	seq_t        exp_seq;
	cnt_sent_t   exp_cnt;
	int          last_len;
	apb_data_t   last_p0;
	apb_data_t   last_p1;

	commu_top #(
		.GUARD_CYCLES (GUARD)
	) dut (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.rx_active (rx_active),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready)
	);

	// sequencer strobes and the stream both meet at the top level
	bind commu_top commu_main_checker u_main_chk (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rx_active (rx_active),
		.fire_head (fire_head),
		.fire_push (fire_push),
		.fire_tail (fire_tail),
		.done_head (done_head),
		.done_push (done_push),
		.done_tail (done_tail),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// hard stop if a test wedges
	initial begin
		#2_000_000;
		$display("ERROR: simulation time limit reached before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

	// --------------------
	// random bits
	// --------------------
	// x^32 + x^22 + x^2 + x + 1 in right shifting form
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	function automatic logic rand_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	// --------------------
	// bookkeeping and compares
	// --------------------
	task automatic begin_test(input string name);
		cur_test = name;
		err_base = n_errors;
		n_tests++;
	endtask

	task automatic end_test();
		if (n_errors == err_base) begin
			$display("test %s finished, no errors", cur_test);
		end else begin
			n_failed++;
			$display("test %s finished, %0d errors", cur_test, n_errors - err_base);
		end
	endtask

	task automatic note_failure(input string msg);
		n_errors++;
		$display("ERROR %s: %s", cur_test, msg);
	endtask

	task automatic check_byte(input string what, input byte_t exp, input byte_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERROR %s %s: expected %02h, actual %02h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_data(input string what, input apb_data_t exp, input apb_data_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERROR %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input cnt_sent_t exp, input cnt_sent_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERROR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	// --------------------
	// APB master
	// --------------------
	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		int waited;
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk_sys);
		penable <= 1'b1;
		waited = 0;
		@(negedge clk_sys);
		while (!pready && waited < WAIT_LIMIT) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			waited++;
		end
		if (!pready)
			note_failure("APB transfer never completed");
		rdata = prdata;
		err   = pslverr;
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rd;
		logic      err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_data($sformatf("pslverr on write %02h", addr), 32'h0, apb_data_t'(err));
	endtask

	task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
		logic err;
		apb_xfer(1'b0, addr, 32'h0, data, err);
		check_data($sformatf("pslverr on read %02h", addr), 32'h0, apb_data_t'(err));
	endtask

	task automatic wait_not_busy();
		apb_data_t ctrl;
		int        polls;
		polls = 0;
		read_reg(REG_CTRL, ctrl);
		while (ctrl[1] && polls < WAIT_LIMIT) begin
			read_reg(REG_CTRL, ctrl);
			polls++;
		end
		if (ctrl[1])
			note_failure("sequencer still busy long after the frame");
		check_data("CTRL when idle", 32'h0, ctrl);
	endtask

	// --------------------
	// stream sink and model
	// --------------------
	// tx_ready is the AND of ready_bits random bits
	task automatic collect_frame(input int nbytes, input int ready_bits);
		int   waited;
		int   k;
		logic rdy;
		rx_q.delete();
		waited = 0;
		while (rx_q.size() < nbytes && waited < WAIT_LIMIT) begin
			@(posedge clk_sys);
			rdy = 1'b1;
			for (k = 0; k < ready_bits; k++)
				rdy = rdy & rand_bit();
			tx_ready <= rdy;
			@(negedge clk_sys);
			if (tx_valid && tx_ready)
				rx_q.push_back(tx_data);
			waited++;
		end
		@(posedge clk_sys);
		tx_ready <= 1'b0;
		if (rx_q.size() < nbytes)
			note_failure($sformatf("stream gave %0d of %0d bytes before the timeout",
				rx_q.size(), nbytes));
	endtask

	task automatic expect_quiet(input int cycles);
		int n;
		int seen;
		seen = 0;
		for (n = 0; n < cycles; n++) begin
			@(posedge clk_sys);
			tx_ready <= 1'b1;
			@(negedge clk_sys);
			if (tx_valid)
				seen++;
		end
		@(posedge clk_sys);
		tx_ready <= 1'b0;
		if (seen != 0)
			note_failure($sformatf("stream was active in %0d cycles of a quiet window", seen));
	endtask

	// byte 0 is the low byte of PAY0
	function automatic byte_t pay_byte(input apb_data_t p0, input apb_data_t p1, input int i);
		if (i < 4)
			return p0[8*i +: 8];
		else
			return p1[8*(i-4) +: 8];
	endfunction

	task automatic build_expected(input seq_t s, input int n, input apb_data_t p0,
			input apb_data_t p1);
		byte_t csum;
		int    i;
		exp_q.delete();
		exp_q.push_back(8'hA5);
		exp_q.push_back(s);
		exp_q.push_back(byte_t'(n));
		csum = s ^ byte_t'(n);
		for (i = 0; i < n; i++) begin
			exp_q.push_back(pay_byte(p0, p1, i));
			csum = csum ^ pay_byte(p0, p1, i);
		end
		exp_q.push_back(csum);
	endtask

	task automatic load_frame(input int n, input apb_data_t p0, input apb_data_t p1);
		write_reg(REG_PAY0, p0);
		write_reg(REG_PAY1, p1);
		write_reg(REG_LEN, apb_data_t'(n));
		last_len = n;
		last_p0  = p0;
		last_p1  = p1;
	endtask

	task automatic check_status();
		apb_data_t status;
		read_reg(REG_STATUS, status);
		check_count("sent count", exp_cnt, cnt_sent_t'(status[15:0]));
		check_byte("sequence", exp_seq, status[23:16]);
	endtask

	// expects the frame built from the last loaded registers
	task automatic receive_and_check(input int ready_bits);
		int i;
		build_expected(exp_seq, last_len, last_p0, last_p1);
		collect_frame(exp_q.size(), ready_bits);
		for (i = 0; i < exp_q.size() && i < rx_q.size(); i++)
			check_byte($sformatf("frame byte %0d", i), exp_q[i], rx_q[i]);
		wait_not_busy();
		check_status();
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic test_reset_state();
		apb_data_t rd;
		begin_test("reset_state");
		@(negedge clk_sys);
		check_data("tx_valid", 32'h0, apb_data_t'(tx_valid));
		read_reg(REG_CTRL, rd);
		check_data("CTRL", 32'h0, rd);
		read_reg(REG_STATUS, rd);
		check_data("STATUS", 32'h0, rd);
		end_test();
	endtask

	task automatic test_reg_access();
		apb_data_t rd;
		logic      err;
		begin_test("reg_access");
		write_reg(REG_PAY0, 32'h1234_5678);
		read_reg(REG_PAY0, rd);
		check_data("PAY0", 32'h1234_5678, rd);
		write_reg(REG_PAY1, 32'h9abc_def0);
		read_reg(REG_PAY1, rd);
		check_data("PAY1", 32'h9abc_def0, rd);
		write_reg(REG_LEN, 32'd6);
		read_reg(REG_LEN, rd);
		check_data("LEN", 32'd6, rd);
		write_reg(REG_LEN, 32'd13);
		read_reg(REG_LEN, rd);
		check_data("LEN above 8", 32'd8, rd);
		// bits 0 and 1 clear so no frame
		write_reg(REG_RETRY, 32'h5c);
		read_reg(REG_RETRY, rd);
		check_data("RETRY", 32'h5c, rd);
		write_reg(REG_RETRY, 32'h0);
		apb_xfer(1'b0, 8'h0c, 32'h0, rd, err);
		check_data("pslverr unmapped", 32'h1, apb_data_t'(err));
		apb_xfer(1'b1, REG_STATUS, 32'hffff_ffff, rd, err);
		check_data("pslverr STATUS write", 32'h1, apb_data_t'(err));
		read_reg(REG_STATUS, rd);
		check_data("STATUS after write", 32'h0, rd);
		end_test();
	endtask

	task automatic test_send(input string name, input int n, input apb_data_t p0,
			input apb_data_t p1, input int ready_bits);
		begin_test(name);
		load_frame(n, p0, p1);
		write_reg(REG_CTRL, 32'h1);
		exp_seq = exp_seq + 1'b1;
		exp_cnt = exp_cnt + 1'b1;
		receive_and_check(ready_bits);
		end_test();
	endtask

	task automatic test_retry();
		apb_data_t rd;
		begin_test("retry");
		write_reg(REG_RETRY, 32'h3);
		exp_cnt = exp_cnt + 1'b1;
		receive_and_check(1);
		read_reg(REG_RETRY, rd);
		check_data("RETRY after resend", 32'h0, rd);
		end_test();
	endtask

	task automatic test_retry_invalid();
		apb_data_t rd;
		begin_test("retry_invalid");
		write_reg(REG_RETRY, 32'h1);
		expect_quiet(60);
		read_reg(REG_RETRY, rd);
		check_data("RETRY kept", 32'h1, rd);
		check_status();
		write_reg(REG_RETRY, 32'h0);
		end_test();
	endtask

	task automatic test_line_holdoff();
		begin_test("line_holdoff");
		@(posedge clk_sys);
		rx_active <= 1'b1;
		load_frame(3, 32'h0706_0504, 32'h0b0a_0908);
		write_reg(REG_CTRL, 32'h1);
		exp_seq = exp_seq + 1'b1;
		exp_cnt = exp_cnt + 1'b1;
		expect_quiet(30);
		@(posedge clk_sys);
		rx_active <= 1'b0;
		// guard time after the received frame
		expect_quiet(GUARD);
		receive_and_check(1);
		end_test();
	endtask

	initial begin
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		rx_active  = 1'b0;
		tx_ready   = 1'b0;
		lfsr_state = SEED;
		n_tests    = 0;
		n_failed   = 0;
		n_checks   = 0;
		n_errors   = 0;
		exp_seq    = '0;
		exp_cnt    = '0;
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);

		test_reset_state();
		test_reg_access();
		test_send("send_len5", 5, 32'h4d3c_2b1a, 32'h8877_665e, 1);
		test_send("send_len0", 0, 32'hcafe_0001, 32'h0000_0002, 1);
		test_send("send_stall", 8, 32'hdead_beef, 32'h0bad_f00d, 3);
		test_retry();
		test_retry_invalid();
		test_line_holdoff();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			n_tests, n_failed, n_checks, n_errors);
		if (n_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/commu_pkg.sv
rtl/commu_regs.sv
rtl/commu_main.sv
rtl/commu_phase_tx.sv
rtl/commu_top.sv
verification/commu_main_checker.sv
verification/commu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = commu_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
